//--- common/cache_array_if.sv
/*
 addressing and write strobes shared by the metadata and data arrays
 one index for both arrays, so a fill and its tag write always land in the same set
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

interface cache_array_if;

	logic [`INDEX_W-1:0] index; // from current cache address
	logic [`OFFSET_W-1:0] offset; // fill counter or processor offset
	logic data_wr; // data array write strobe
	logic tag_wr; // metadata write strobe
	logic [`WORD_W-1:0] wdata; // reg_in on a hit, mem_data on a fill
	cache_pkg::meta_entry_t meta_wdata; // valid entry with current tag

	// fill controller owns the timing of every write
	modport controller (
		output offset,
		output data_wr,
		output tag_wr
	);

	// top level supplies address and data
	modport dcache (
		output index,
		output wdata,
		output meta_wdata
	);

	modport array (
		input index,
		input offset,
		input data_wr,
		input tag_wr,
		input wdata,
		input meta_wdata
	);

endinterface

`default_nettype wire

//--- common/cache_defs.svh
/*
 address split and array geometry for the data cache
 widths assume 16-bit word addressing with bit 0 always zero
 tag + index + offset + 1 must equal WORD_W
*/
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// address fields, msb to lsb
`define TAG_W 5
`define INDEX_W 7
`define OFFSET_W 3 // word offset, byte bit sits below it

// data path width, also the address width
`define WORD_W 16

// direct mapped, one block per set
`define NUM_BLOCKS 128
`define WORDS_PER_BLOCK 8 // 16 byte blocks

`endif

//--- common/cache_pkg.sv
/*
 cache side types: the address word and one metadata entry
 byte_sel is expected to be zero, byte writes are not supported
*/
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

	// field view of a processor address
	typedef struct packed {
		logic [`TAG_W-1:0] tag;
		logic [`INDEX_W-1:0] index; // selects the block
		logic [`OFFSET_W-1:0] offset; // word within block
		logic byte_sel; // always 0 from the processor
	} addr_fields_t;

	// raw word goes out on the memory bus, fields feed the arrays
	typedef union packed {
		logic [`WORD_W-1:0] raw;
		addr_fields_t f;
	} cache_addr_t;

	// one entry of the metadata array
	typedef struct packed {
		logic valid; // block holds real data
		logic [1:0] spare; // unused, written as zero
		logic [`TAG_W-1:0] tag;
	} meta_entry_t;

endpackage

`default_nettype wire

//--- common/fill_pkg.sv
/*
 fill controller types
 the word counter wraps at the block size, so WORDS_PER_BLOCK must be 2**OFFSET_W
*/
`default_nettype none
`include "cache_defs.svh"

package fill_pkg;

	typedef enum logic [1:0] {
		st_idle, // hits and write-through only
		st_fill, // block words coming back from memory
		st_tag, // one cycle, metadata write
		st_wait_release // one cycle, processor consumes the filled word
	} fill_state_t;

	// words requested and received in the current fill
	typedef logic [`OFFSET_W-1:0] word_cnt_t;

endpackage

`default_nettype wire

//--- dcache/cache_fill_fsm.sv
/*
 miss handling and write-through for the data cache
 a fill requests the block word by word with read_req held high, then writes the tag
 a fill only starts while ifsm_busy is low; write-throughs are not acknowledged
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_fill_fsm (
	input wire clk,
	input wire reset,
	input wire wrt_en, // processor write, already gated by mem_en
	input wire miss,
	input wire mem_data_vld, // one cycle per returned word
	input wire pause, // instruction fill owns the memory
	input wire [`WORD_W-1:0] addr_in,
	output logic read_req,
	output logic wrt_mem,
	output logic fsm_busy,
	output logic [`WORD_W-1:0] miss_addr,
	cache_array_if.controller arr
);

	fill_pkg::fill_state_t state;
	fill_pkg::fill_state_t state_nxt;
	fill_pkg::word_cnt_t cnt; // current word of the block
	cache_pkg::cache_addr_t cpu_addr;
	cache_pkg::cache_addr_t fill_addr; // block base plus counter
	logic filling;
	logic last_word;
	logic hit_wr; // write hit, a fill always sees a miss

	assign cpu_addr.raw = addr_in;

	always_comb begin
		fill_addr = cpu_addr;
		fill_addr.f.offset = cnt;
		fill_addr.f.byte_sel = 1'b0;
	end

	assign filling = (state == fill_pkg::st_fill);
	assign last_word = (cnt == fill_pkg::word_cnt_t'(`WORDS_PER_BLOCK - 1));

	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			fill_pkg::st_idle: begin
				if (miss && !pause)
					state_nxt = fill_pkg::st_fill;
			end
			fill_pkg::st_fill: begin
				if (mem_data_vld && last_word)
					state_nxt = fill_pkg::st_tag; // eighth word arrives
			end
			fill_pkg::st_tag: state_nxt = fill_pkg::st_wait_release;
			fill_pkg::st_wait_release: state_nxt = fill_pkg::st_idle; // hit path runs here
			default: state_nxt = fill_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fill_pkg::st_idle;
			cnt <= '0;
		end else begin
			state <= state_nxt;
			if (filling && mem_data_vld)
				cnt <= cnt + 1'b1; // wraps to 0 after the last word
			else if (!filling)
				cnt <= '0;
		end
	end

	// tag state forces a miss upstream, keep it out explicitly anyway
	assign hit_wr = wrt_en && !miss && (state != fill_pkg::st_tag);

	assign read_req = filling; // level, held through stalls
	assign wrt_mem = hit_wr; // write through, same edge as the array
	assign fsm_busy = filling || (state == fill_pkg::st_tag);
	assign miss_addr = filling ? fill_addr.raw : cpu_addr.raw;

	// array side
	assign arr.offset = filling ? cnt : cpu_addr.f.offset;
	assign arr.data_wr = filling ? mem_data_vld : hit_wr;
	assign arr.tag_wr = (state == fill_pkg::st_tag);

	// the tag is only written right after a completed fill
	a_tag_after_fill: assert property (@(posedge clk) disable iff (reset)
		$rose(arr.tag_wr) |-> $past(state) == fill_pkg::st_fill && $past(last_word));

	// memory sees either a fill or a write-through, never both
	a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(read_req && wrt_mem));

endmodule

`default_nettype wire

//--- dcache/data_array.sv
/*
 block data, 128 sets of 8 16-bit words, no reset
 contents are undefined until a fill writes them; one word written per cycle
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module data_array (
	input wire clk,
	cache_array_if.array arr,
	output logic [`WORD_W-1:0] data_out
);

	logic [`WORD_W-1:0] words [`NUM_BLOCKS][`WORDS_PER_BLOCK];

	// fill words and write hits share this port
	always_ff @(posedge clk) begin
		if (arr.data_wr)
			words[arr.index][arr.offset] <= arr.wdata;
	end

	assign data_out = words[arr.index][arr.offset]; // async read

	// the tag write that closes a fill goes to the set that took its last word
	a_fill_same_set: assert property (@(posedge clk)
		(arr.data_wr ##1 arr.tag_wr) |-> arr.index == $past(arr.index));

endmodule

`default_nettype wire

//--- dcache/dcache.sv
/*
 direct mapped data cache, 128 blocks of 16 bytes, write through with write allocate
 processor must stall while fsm_busy is high and hold its request until it falls
 memory is assumed to complete a write-through in the same cycle as the cache
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module dcache (
	input wire clk,
	input wire reset,
	input wire mem_en, // processor touches memory this cycle
	input wire wrt_en, // processor write
	input wire [`WORD_W-1:0] addr_in,
	input wire [`WORD_W-1:0] reg_in, // store data from register file
	input wire [`WORD_W-1:0] mem_data, // fill data from main memory
	input wire mem_data_vld,
	input wire ifsm_busy, // instruction side fill in progress
	output logic read_req,
	output logic wrt_mem,
	output logic fsm_busy, // doubles as the pipeline stall
	output logic [`WORD_W-1:0] miss_addr,
	output logic [`WORD_W-1:0] data_out
);

	cache_pkg::cache_addr_t addr; // processor address, split into fields
	cache_pkg::meta_entry_t meta_out; // entry at current index
	logic hit;

	cache_array_if arr_if ();

	assign addr.raw = addr_in;

	// both arrays see the same set
	assign arr_if.index = addr.f.index;

	// store data on a hit, otherwise this is a fill word
	assign arr_if.wdata = hit ? reg_in : mem_data;

	// the only entry ever written: valid, current tag
	assign arr_if.meta_wdata = '{valid: 1'b1, spare: 2'b00, tag: addr.f.tag};

	// idle bus counts as a hit so no fill starts
	// during the tag write the entry is changing, treat as a miss
	always_comb begin
		if (!mem_en)
			hit = 1'b1;
		else if (arr_if.tag_wr)
			hit = 1'b0;
		else
			hit = meta_out.valid && (meta_out.tag == addr.f.tag);
	end

	cache_fill_fsm i_fill_fsm (
		.clk (clk),
		.reset (reset),
		.wrt_en (wrt_en & mem_en), // no write-through when bus is idle
		.miss (~hit),
		.mem_data_vld (mem_data_vld),
		.pause (ifsm_busy),
		.addr_in (addr_in),
		.read_req (read_req),
		.wrt_mem (wrt_mem),
		.fsm_busy (fsm_busy),
		.miss_addr (miss_addr),
		.arr (arr_if.controller)
	);

	meta_array i_meta_array (
		.clk (clk),
		.reset (reset),
		.arr (arr_if.array),
		.meta_out (meta_out)
	);

	data_array i_data_array (
		.clk (clk),
		.arr (arr_if.array),
		.data_out (data_out) // combinational read, same cycle as addr_in
	);

endmodule

`default_nettype wire

//--- dcache/meta_array.sv
/*
 valid bit and tag per block, all entries cleared by reset
 written once per fill through tag_wr; read is combinational from index
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module meta_array (
	input wire clk,
	input wire reset,
	cache_array_if.array arr,
	output cache_pkg::meta_entry_t meta_out
);

	cache_pkg::meta_entry_t entries [`NUM_BLOCKS]; // one per set

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_BLOCKS; i++)
				entries[i] <= '0; // nothing valid after reset
		end else if (arr.tag_wr) begin
			entries[arr.index] <= arr.meta_wdata;
		end
	end

	assign meta_out = entries[arr.index]; // async read for hit check

	// a tag write must always mark the block valid, otherwise the fill is lost
	a_tag_wr_valid: assert property (@(posedge clk) disable iff (reset)
		arr.tag_wr |-> arr.meta_wdata.valid);

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/cache_pkg.sv
common/fill_pkg.sv
common/cache_array_if.sv
dcache/meta_array.sv
dcache/data_array.sv
dcache/cache_fill_fsm.sv
dcache/dcache.sv
tests/mem_model.sv
tests/tb_dcache.sv

//--- tests/mem_model.sv
/*
 main memory behind the data cache, 32K words of 16 bits, contents loaded by the testbench
 a requested word returns 3 cycles after read_req rises or after the previous return
 write-through pulses complete at the edge where they are seen
*/
`timescale 1ns/1ps
`default_nettype none

module mem_model (
	input wire clk,
	input wire reset,
	input wire read_req, // level, held through a whole fill
	input wire wrt_mem, // one cycle per write-through
	input wire [15:0] addr, // bit 0 ignored
	input wire [15:0] wdata,
	output logic [15:0] rdata,
	output logic rdata_vld
);

	logic [15:0] words [32768];
	logic [1:0] delay; // cycles since request or last return

	// one strobe every third cycle while read_req holds
	always_ff @(posedge clk) begin
		if (reset || !read_req) begin
			delay <= 2'd0;
			rdata_vld <= 1'b0;
			rdata <= 16'h0000;
		end else if (delay == 2'd2) begin
			delay <= 2'd0;
			rdata_vld <= 1'b1;
			rdata <= words[addr[15:1]]; // addr already carries the fill counter
		end else begin
			delay <= delay + 2'd1;
			rdata_vld <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (wrt_mem)
			words[addr[15:1]] <= wdata;
	end

endmodule

`default_nettype wire

//--- tests/tb_dcache.sv
/*
 testbench for the data cache with a memory model on the memory ports
 the processor side holds each request until fsm_busy falls
 ifsm_busy is raised once to hold off a fill, otherwise it stays low
 expected data comes from a shadow copy of the random memory image
*/
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

	logic clk;
	logic reset;
	logic mem_en;
	logic wrt_en;
	logic [15:0] addr_in;
	logic [15:0] reg_in;
	logic ifsm_busy;
	wire [15:0] mem_data;
	wire mem_data_vld;
	wire read_req;
	wire wrt_mem;
	wire fsm_busy;
	wire [15:0] miss_addr;
	wire [15:0] data_out;

	logic [15:0] shadow [32768]; // memory as the processor expects it
	logic [5:0] tag_model [128]; // valid bit and tag for each set
	int checks;
	int errors;
	logic [15:0] got_data; // last completed read
	logic [15:0] got_addr;
	event read_done;

	dcache i_dut (
		.clk (clk),
		.reset (reset),
		.mem_en (mem_en),
		.wrt_en (wrt_en),
		.addr_in (addr_in),
		.reg_in (reg_in),
		.mem_data (mem_data),
		.mem_data_vld (mem_data_vld),
		.ifsm_busy (ifsm_busy),
		.read_req (read_req),
		.wrt_mem (wrt_mem),
		.fsm_busy (fsm_busy),
		.miss_addr (miss_addr),
		.data_out (data_out)
	);

	mem_model i_mem (
		.clk (clk),
		.reset (reset),
		.read_req (read_req),
		.wrt_mem (wrt_mem),
		.addr (miss_addr),
		.wdata (reg_in), // write-through data is the store data
		.rdata (mem_data),
		.rdata_vld (mem_data_vld)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] expected_word(input logic [15:0] addr);
		return shadow[addr[15:1]];
	endfunction

	// direct mapped, so one tag per set
	function automatic logic is_cached(input logic [15:0] addr);
		return tag_model[addr[10:4]] == {1'b1, addr[15:11]};
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	// polls at negedges until fsm_busy reaches level, at most 200 cycles
	task automatic wait_busy(input logic level, input string what);
		int n;
		n = 0;
		while (fsm_busy !== level && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (fsm_busy !== level) begin
			errors++;
			$display("timeout: fsm_busy did not %s within 200 cycles at %0t", what, $time);
			finish_run();
		end
	endtask

	// one processor access, held until the cache lets it go
	task automatic access(input logic wr, input logic [15:0] addr, input logic [15:0] data);
		logic miss;
		miss = !is_cached(addr);
		@(posedge clk);
		mem_en <= 1'b1;
		wrt_en <= wr;
		addr_in <= addr;
		reg_in <= data;
		@(negedge clk);
		if (miss) begin
			wait_busy(1'b1, "rise");
			check_value("read_req", read_req, 16'h1);
			wait_busy(1'b0, "fall"); // release cycle, hit path is live
			tag_model[addr[10:4]] = {1'b1, addr[15:11]};
		end
		if (wr) begin
			check_value("wrt_mem", wrt_mem, 16'h1);
			check_value("miss_addr", miss_addr, addr);
			shadow[addr[15:1]] = data;
		end else begin
			got_data = data_out;
			got_addr = addr;
			-> read_done;
		end
		@(posedge clk);
		mem_en <= 1'b0;
		wrt_en <= 1'b0;
		@(negedge clk);
		check_value("fsm_busy", fsm_busy, 16'h0); // a hit must not start a fill
	endtask

	// every completed read against the shadow image
	always @(read_done)
		check_value("data_out", got_data, expected_word(got_addr));

	initial begin
		int unsigned seed;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] d;
		logic [15:0] r;
		seed = 32'h909c;
		void'($urandom(seed));
		checks = 0;
		errors = 0;
		reset = 1'b1;
		mem_en = 1'b0;
		wrt_en = 1'b0;
		addr_in = 16'h0000;
		reg_in = 16'h0000;
		ifsm_busy = 1'b0;
		for (int i = 0; i < 32768; i++) begin
			shadow[i] = 16'($urandom);
			i_mem.words[i] = shadow[i];
		end
		for (int i = 0; i < 128; i++)
			tag_model[i] = 6'h00; // nothing valid after reset
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("read_req", read_req, 16'h0);
		check_value("wrt_mem", wrt_mem, 16'h0);
		check_value("fsm_busy", fsm_busy, 16'h0);

		a = 16'($urandom) & 16'hfff0; // block base
		b = a ^ 16'h0130; // other set
		c = a ^ 16'h0800; // same set, other tag
		// cold miss, then the whole block hits
		access(1'b0, a | 16'h0006, 16'h0000);
		for (int w = 0; w < 8; w++)
			access(1'b0, a | 16'(2 * w), 16'h0000);
		// write hit goes through to memory
		d = 16'($urandom);
		access(1'b1, a | 16'h0004, d);
		check_value("mem_word", i_mem.words[a[15:1] | 15'h0002], expected_word(a | 16'h0004));
		access(1'b0, a | 16'h0004, 16'h0000);
		// write miss allocates first
		d = 16'($urandom);
		access(1'b1, b | 16'h0006, d);
		for (int w = 0; w < 8; w++)
			access(1'b0, b | 16'(2 * w), 16'h0000);
		// eviction back and forth
		access(1'b0, c | 16'h0002, 16'h0000);
		access(1'b0, a | 16'h0004, 16'h0000);
		access(1'b0, c | 16'h000e, 16'h0000);

		// instruction side owns the memory, the fill of a waits for it
		@(posedge clk);
		ifsm_busy <= 1'b1;
		fork
			access(1'b0, a | 16'h000a, 16'h0000);
			begin
				repeat (5) begin
					@(negedge clk);
					check_value("fsm_busy", fsm_busy, 16'h0);
				end
				@(posedge clk);
				ifsm_busy <= 1'b0;
				repeat (2) @(negedge clk);
				check_value("fsm_busy", fsm_busy, 16'h1); // fill starts at the first free edge
			end
		join

		// idle bus, nothing may happen
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			wrt_en <= 1'($urandom);
			addr_in <= 16'($urandom) & 16'hfffe;
			reg_in <= 16'($urandom);
			@(negedge clk);
			check_value("fsm_busy", fsm_busy, 16'h0);
			check_value("read_req", read_req, 16'h0);
			check_value("wrt_mem", wrt_mem, 16'h0);
		end

		// mixed traffic over a few sets and two tags
		for (int i = 0; i < 30; i++) begin
			r = {4'h0, 1'($urandom), a[10:6], 2'($urandom), 3'($urandom), 1'b0};
			access(1'($urandom), r, 16'($urandom));
		end
		finish_run();
	end

endmodule

`default_nettype wire
